// File: hdl/agu_pkg.sv
package agu_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [15:0] sel_t;
    typedef logic [2:0]  reg_idx_t;
    typedef logic [1:0]  scale_t;
    typedef logic [1:0]  size_t;
    typedef logic [31:0] uop_word_t;

    localparam int num_gpr = 8;
    localparam int num_seg = 6;

    // Micro-op word layout, low bit of each field
    localparam int base_lsb      = 0;
    localparam int index_lsb     = 3;
    localparam int scale_lsb     = 6;
    localparam int use_base_bit  = 8;
    localparam int use_index_bit = 9;
    localparam int seg_lsb       = 10;
    localparam int opsize_lsb    = 13;
    localparam int mem_rw_lsb    = 15;
    localparam int dest_lsb      = 17;
    localparam int dest_ld_bit   = 20;
    localparam int disp_lsb      = 21;
    localparam int disp_w        = 11;  // Signed, sits in the top bits of the word

    // Highest linear address each segment may touch, indexed by segment number
    localparam addr_t seg_limit [num_seg] = '{
        32'h0000_ffff,
        32'h0001_ffff,
        32'h0000_7fff,
        32'h000f_ffff,
        32'h0000_0fff,
        32'hffff_ffff
    };

endpackage

// File: hdl/uop_if.sv
`timescale 1ns/1ps

interface uop_if
    import agu_pkg::*;
();

    logic     valid;
    logic     hold;
    reg_idx_t base;
    reg_idx_t index;
    scale_t   scale;
    logic     use_base;
    logic     use_index;
    reg_idx_t seg;
    size_t    opsize;
    logic [1:0] mem_rw;
    reg_idx_t dest;
    logic     dest_ld;
    addr_t    disp;

    modport source (output valid, base, index, scale, use_base, use_index, seg, opsize,
                    mem_rw, dest, dest_ld, disp, input hold);

    modport sink (input valid, base, index, scale, use_base, use_index, seg, opsize,
                  mem_rw, dest, dest_ld, disp, output hold);

endinterface

// File: hdl/uop_decode.sv
`timescale 1ns/1ps

module uop_decode
    import agu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      uop_valid,
    input  uop_word_t uop_word,
    output logic      stall,
    uop_if.source     dec
);

    logic      valid_q;
    uop_word_t word_q;
    logic      accept;

    assign stall  = valid_q & dec.hold;  // Full and execute cannot take the item
    assign accept = uop_valid & ~stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= uop_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            word_q <= uop_word;
        end
    end

    assign dec.valid     = valid_q;
    assign dec.base      = word_q[base_lsb +: $bits(reg_idx_t)];
    assign dec.index     = word_q[index_lsb +: $bits(reg_idx_t)];
    assign dec.scale     = word_q[scale_lsb +: $bits(scale_t)];
    assign dec.use_base  = word_q[use_base_bit];
    assign dec.use_index = word_q[use_index_bit];
    assign dec.seg       = word_q[seg_lsb +: $bits(reg_idx_t)];
    assign dec.opsize    = word_q[opsize_lsb +: $bits(size_t)];
    assign dec.mem_rw    = word_q[mem_rw_lsb +: 2];
    assign dec.dest      = word_q[dest_lsb +: $bits(reg_idx_t)];
    assign dec.dest_ld   = word_q[dest_ld_bit];

    // Displacement is sign-extended to the full address width
    assign dec.disp = {{($bits(addr_t) - disp_w){word_q[disp_lsb + disp_w - 1]}},
                       word_q[disp_lsb +: disp_w]};

endmodule

// File: hdl/gpr_file.sv
`timescale 1ns/1ps

module gpr_file
    import agu_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rd_a,
    input  reg_idx_t rd_b,
    output addr_t    val_a,
    output addr_t    val_b,
    output logic     pend_a,
    output logic     pend_b,
    input  logic     set_en,
    input  reg_idx_t set_reg,
    input  logic     wb_en,
    input  reg_idx_t wb_reg,
    input  addr_t    wb_data
);

    addr_t              regs [num_gpr];
    logic [num_gpr-1:0] pend;

    // Register values
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_gpr; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_reg] <= wb_data;
        end
    end

    // A writeback clears after the set, so it wins on the same register
    always_ff @(posedge clk) begin
        if (reset) begin
            pend <= '0;
        end else begin
            if (set_en) begin
                pend[set_reg] <= 1'b1;
            end
            if (wb_en) begin
                pend[wb_reg] <= 1'b0;
            end
        end
    end

    assign val_a  = regs[rd_a];
    assign val_b  = regs[rd_b];
    assign pend_a = pend[rd_a];
    assign pend_b = pend[rd_b];

endmodule

// File: hdl/seg_file.sv
`timescale 1ns/1ps

module seg_file
    import agu_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rd_seg,
    output sel_t     sel,
    output logic     pend,
    input  logic     wb_en,
    input  reg_idx_t wb_seg,
    input  sel_t     wb_data
);

    sel_t               segs [num_seg];
    logic [num_seg-1:0] pend_q;
    logic               lock;

    // Number 7 is not a segment, a write there reserves the segment named in the data
    assign lock = wb_en & (wb_seg == 3'd7) & (wb_data[2:0] < num_seg);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_seg; i++) begin
                segs[i] <= '0;
            end
            pend_q <= '0;
        end else begin
            if (lock) begin
                pend_q[wb_data[2:0]] <= 1'b1;
            end
            if (wb_en && wb_seg < num_seg) begin
                segs[wb_seg]   <= wb_data;
                pend_q[wb_seg] <= 1'b0;
            end
        end
    end

    assign sel  = (rd_seg < num_seg) ? segs[rd_seg] : '0;
    assign pend = (rd_seg < num_seg) ? pend_q[rd_seg] : 1'b0;

endmodule

// File: hdl/rrag.sv
`timescale 1ns/1ps

module rrag
    import agu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    uop_if.sink        dec,
    output reg_idx_t   rd_a,
    output reg_idx_t   rd_b,
    input  addr_t      val_a,
    input  addr_t      val_b,
    input  logic       pend_a,
    input  logic       pend_b,
    output reg_idx_t   rd_seg,
    input  sel_t       sel,
    input  logic       seg_pend,
    output logic       set_en,
    output reg_idx_t   set_reg,
    output logic       res_valid,
    output addr_t      res_addr,
    output size_t      res_size,
    output reg_idx_t   res_seg,
    output logic [1:0] res_rw,
    input  logic       res_hold
);

    logic  src_wait;
    logic  out_busy;
    logic  issue;
    addr_t seg_base;
    addr_t base_val;
    addr_t index_val;
    addr_t lin_addr;

    assign rd_a   = dec.base;
    assign rd_b   = dec.index;
    assign rd_seg = dec.seg;

    // A source register or the segment still waits for its writeback
    assign src_wait = (dec.use_base & pend_a) | (dec.use_index & pend_b) | seg_pend;
    assign out_busy = res_valid & res_hold;

    assign dec.hold = src_wait | out_busy;
    assign issue    = dec.valid & ~dec.hold;

    // Real-mode style segment base, selector times sixteen
    assign seg_base  = {12'h000, sel, 4'h0};
    assign base_val  = dec.use_base ? val_a : '0;
    assign index_val = dec.use_index ? (val_b << dec.scale) : '0;
    assign lin_addr  = seg_base + base_val + index_val + dec.disp;

    assign set_en  = issue & dec.dest_ld;  // Destination is busy until its writeback
    assign set_reg = dec.dest;

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else if (!out_busy) begin
            res_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            res_addr <= lin_addr;
            res_size <= dec.opsize;
            res_seg  <= dec.seg;
            res_rw   <= dec.mem_rw;
        end
    end

endmodule

// File: hdl/addr_result.sv
`timescale 1ns/1ps

module addr_result
    import agu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       res_valid,
    input  addr_t      res_addr,
    input  size_t      res_size,
    input  reg_idx_t   res_seg,
    input  logic [1:0] res_rw,
    output logic       res_hold,
    output logic       out_valid,
    input  logic       out_ready,
    output addr_t      mem_addr,
    output addr_t      mem_end,
    output logic       limit_fault,
    output logic [1:0] mem_rw
);

    addr_t last_byte;
    logic  over_limit;
    logic  take;

    // Size code n covers 2**n bytes
    assign last_byte = res_addr + ((addr_t'(1) << res_size) - addr_t'(1));

    // Unknown segment numbers always fault
    assign over_limit = (res_seg < num_seg) ? (last_byte > seg_limit[res_seg]) : 1'b1;

    assign res_hold = out_valid & ~out_ready;
    assign take     = res_valid & ~res_hold;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (!res_hold) begin
            out_valid <= res_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            mem_addr    <= res_addr;
            mem_end     <= last_byte;
            limit_fault <= over_limit;
            mem_rw      <= res_rw;
        end
    end

endmodule

// File: hdl/rrag_top.sv
`timescale 1ns/1ps

module rrag_top
    import agu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       uop_valid,
    input  uop_word_t  uop_word,
    output logic       stall,
    input  logic       wb_en,
    input  reg_idx_t   wb_reg,
    input  addr_t      wb_data,
    input  logic       wb_seg_en,
    input  reg_idx_t   wb_seg,
    input  sel_t       wb_seg_data,
    output logic       out_valid,
    input  logic       out_ready,
    output addr_t      mem_addr,
    output addr_t      mem_end,
    output logic       limit_fault,
    output logic [1:0] mem_rw
);

    uop_if dec_bus ();

    reg_idx_t   rd_a;
    reg_idx_t   rd_b;
    addr_t      val_a;
    addr_t      val_b;
    logic       pend_a;
    logic       pend_b;
    reg_idx_t   rd_seg;
    sel_t       sel;
    logic       seg_pend;
    logic       set_en;
    reg_idx_t   set_reg;
    logic       res_valid;
    addr_t      res_addr;
    size_t      res_size;
    reg_idx_t   res_seg;
    logic [1:0] res_rw;
    logic       res_hold;

    uop_decode decode_inst (.clk(clk), .reset(reset), .uop_valid(uop_valid),
                            .uop_word(uop_word), .stall(stall), .dec(dec_bus));

    gpr_file gpr_inst (.clk(clk), .reset(reset), .rd_a(rd_a), .rd_b(rd_b),
                       .val_a(val_a), .val_b(val_b), .pend_a(pend_a), .pend_b(pend_b),
                       .set_en(set_en), .set_reg(set_reg),
                       .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data));

    seg_file seg_inst (.clk(clk), .reset(reset), .rd_seg(rd_seg), .sel(sel), .pend(seg_pend),
                       .wb_en(wb_seg_en), .wb_seg(wb_seg), .wb_data(wb_seg_data));

    rrag rrag_inst (.clk(clk), .reset(reset), .dec(dec_bus),
                    .rd_a(rd_a), .rd_b(rd_b), .val_a(val_a), .val_b(val_b),
                    .pend_a(pend_a), .pend_b(pend_b),
                    .rd_seg(rd_seg), .sel(sel), .seg_pend(seg_pend),
                    .set_en(set_en), .set_reg(set_reg),
                    .res_valid(res_valid), .res_addr(res_addr), .res_size(res_size),
                    .res_seg(res_seg), .res_rw(res_rw), .res_hold(res_hold));

    addr_result result_inst (.clk(clk), .reset(reset), .res_valid(res_valid),
                             .res_addr(res_addr), .res_size(res_size), .res_seg(res_seg),
                             .res_rw(res_rw), .res_hold(res_hold),
                             .out_valid(out_valid), .out_ready(out_ready),
                             .mem_addr(mem_addr), .mem_end(mem_end),
                             .limit_fault(limit_fault), .mem_rw(mem_rw));

endmodule

// File: tests/rrag_sva.sv
`timescale 1ns/1ps

module rrag_sva
    import agu_pkg::*;
(
    input logic  clk,
    input logic  reset,
    input logic  stall,
    input logic  out_valid,
    input logic  out_ready,
    input addr_t mem_addr
);

    // A held output keeps its address until it is taken
    property held_addr_stable;
        @(posedge clk) disable iff (reset) out_valid && !out_ready |=> $stable(mem_addr);
    endproperty

    property held_valid_stays;
        @(posedge clk) disable iff (reset) out_valid && !out_ready |=> out_valid;
    endproperty

    assert property (held_addr_stable) else $error("mem_addr changed while out_ready was low");

    assert property (@(posedge clk) reset |=> !stall) else $error("stall high after reset");

    assert property (held_valid_stays) else $error("out_valid fell without a handshake");

endmodule

// File: tests/rrag_tb.sv
`timescale 1ns/1ps

module rrag_tb
    import agu_pkg::*;
();

    logic       clk;
    logic       reset;
    logic       uop_valid;
    uop_word_t  uop_word;
    logic       stall;
    logic       wb_en;
    reg_idx_t   wb_reg;
    addr_t      wb_data;
    logic       wb_seg_en;
    reg_idx_t   wb_seg;
    sel_t       wb_seg_data;
    logic       out_valid;
    logic       out_ready;
    addr_t      mem_addr;
    addr_t      mem_end;
    logic       limit_fault;
    logic [1:0] mem_rw;

    string      case_lines [$];
    addr_t      exp_addr_q [$];
    addr_t      exp_end_q [$];
    logic       exp_fault_q [$];
    logic [1:0] exp_rw_q [$];
    int         exp_test_q [$];
    int         cycle_count = 0;
    int         cycle_limit = 0;
    int         ready_mode = 0;  // 0 always ready, 1 random, 2 never ready
    int         seed = 32'h7250977a;
    int         cur_test = -1;
    int         test_checks = 0;
    int         test_errors = 0;
    int         total_checks = 0;
    int         total_errors = 0;
    logic       accepted;

    rrag_top rrag_top_inst (.*);

    bind rrag_top rrag_sva rrag_sva_inst (.clk(clk), .reset(reset), .stall(stall),
        .out_valid(out_valid), .out_ready(out_ready), .mem_addr(mem_addr));

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_limit > 0 && cycle_count >= cycle_limit);
        $display("Timeout after %0d cycles with %0d outputs still expected",
                 cycle_count, exp_addr_q.size());
        $display("Test failures found");
        $finish;
    end

    task automatic load_cases();
        int    fd;
        string line;
        fd = $fopen("tests/rrag_cases.txt", "r");
        if (fd == 0) begin
            $display("ERROR: the case file tests/rrag_cases.txt could not be opened");
            total_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    case_lines.push_back(line);
                end
            end
            $fclose(fd);
        end
        cycle_limit = 40 * case_lines.size() + 16;
    endtask

    // Inputs change here and all strobes default to low each cycle
    task automatic next_edge();
        logic [31:0] rnd;
        @(negedge clk);
        rnd       = $random(seed);
        uop_valid = 1'b0;
        wb_en     = 1'b0;
        wb_seg_en = 1'b0;
        out_ready = (ready_mode == 0) ? 1'b1 : (ready_mode == 1) ? rnd[0] : 1'b0;
    endtask

    // Sampled mid-cycle so these are the values the next rising edge sees
    task automatic sample_outputs();
        #10;
        accepted = uop_valid & ~stall;
        if (out_valid && out_ready) begin
            assert (exp_addr_q.size() > 0)
            else begin
                $display("ERROR at %0t: an output left with no micro-op outstanding", $time);
                test_errors++;
            end
            if (exp_addr_q.size() > 0) begin
                test_checks++;
                assert (mem_addr == exp_addr_q[0] && mem_end == exp_end_q[0] &&
                        limit_fault == exp_fault_q[0] && mem_rw == exp_rw_q[0])
                else begin
                    $display("MISMATCH at %0t: test %0d got %h %h %b %b, want %h %h %b %b",
                             $time, exp_test_q[0], mem_addr, mem_end, limit_fault, mem_rw,
                             exp_addr_q[0], exp_end_q[0], exp_fault_q[0], exp_rw_q[0]);
                    test_errors++;
                end
                void'(exp_addr_q.pop_front());
                void'(exp_end_q.pop_front());
                void'(exp_fault_q.pop_front());
                void'(exp_rw_q.pop_front());
                void'(exp_test_q.pop_front());
            end
        end
    endtask

    task automatic idle_cycle();
        next_edge();
        sample_outputs();
    endtask

    task automatic close_test();
        while (exp_addr_q.size() > 0) begin
            idle_cycle();
        end
        if (cur_test >= 0) begin
            $display("test %0d done: %0d checks, %0d errors", cur_test, test_checks, test_errors);
        end
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic run_line(string line);
        byte         kind;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        logic [31:0] f5;
        void'($sscanf(line, "%c %h %h %h %h %h", kind, f1, f2, f3, f4, f5));
        case (kind)
            "T": begin
                close_test();
                cur_test = f1;
            end
            "W": begin
                next_edge();
                wb_en   = 1'b1;
                wb_reg  = f1[2:0];
                wb_data = f2;
                sample_outputs();
            end
            "S": begin
                next_edge();
                wb_seg_en   = 1'b1;
                wb_seg      = f1[2:0];
                wb_seg_data = f2[15:0];
                sample_outputs();
            end
            "U": begin
                exp_test_q.push_back(f1);
                exp_addr_q.push_back(f3);
                exp_end_q.push_back(f4);
                exp_fault_q.push_back(f5[0]);
                exp_rw_q.push_back(f2[mem_rw_lsb +: 2]);  // Access type passes through unchanged
                do begin
                    next_edge();
                    uop_valid = 1'b1;
                    uop_word  = f2;
                    sample_outputs();
                end while (!accepted);
            end
            "R": ready_mode = f1;
            "I": repeat (f1) idle_cycle();
            "P": begin
                test_checks++;
                assert (exp_addr_q.size() == f1)
                else begin
                    $display("MISMATCH at %0t: %0d outputs outstanding, expected %0d",
                             $time, exp_addr_q.size(), f1);
                    test_errors++;
                end
                // A presented output must be the oldest one still outstanding
                if (out_valid && exp_addr_q.size() > 0) begin
                    test_checks++;
                    assert (mem_addr == exp_addr_q[0])
                    else begin
                        $display("MISMATCH at %0t: presented addr %h, expected the oldest %h",
                                 $time, mem_addr, exp_addr_q[0]);
                        test_errors++;
                    end
                end
            end
            "K": begin
                test_checks++;
                assert (stall == f1[0] && out_valid == f2[0])
                else begin
                    $display("MISMATCH at %0t: stall %b out_valid %b, expected %b %b",
                             $time, stall, out_valid, f1[0], f2[0]);
                    test_errors++;
                end
            end
            default: begin
                $display("ERROR: the case line '%s' has an unknown kind", line);
                test_errors++;
            end
        endcase
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        uop_valid   = 1'b0;
        uop_word    = '0;
        wb_en       = 1'b0;
        wb_reg      = '0;
        wb_data     = '0;
        wb_seg_en   = 1'b0;
        wb_seg      = '0;
        wb_seg_data = '0;
        out_ready   = 1'b1;
        load_cases();
        repeat (15) idle_cycle();
        next_edge();
        reset = 1'b0;  // Sixteen rising edges saw reset high
        sample_outputs();
        foreach (case_lines[i]) begin
            run_line(case_lines[i]);
        end
        close_test();
        $display("Summary: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: tests/rrag_cases.txt
# T test | W reg value | S seg selector | U test word mem_addr mem_end fault (all hex)
# R ready mode 0 high 1 random 2 low | I idle cycles | P outputs outstanding | K stall out_valid
T 5
K 0 0
U 5 020043d1 00000010 00000013 0
U 5 ffe00d07 ffffffff ffffffff 1
T 1
S 1 1000
S 2 0100
W 1 00000100
W 2 00000020
W 3 00001000
W 5 fffffff0
U 1 00800501 00010104 00010104 0
U 1 00000610 00010020 00010020 0
U 1 ff000751 00010138 00010138 0
U 1 7fe00793 0001147f 0001147f 0
U 1 800006d0 0000fd00 0000fd00 0
U 1 04000b1d 00002010 00002010 0
U 1 24608000 00000123 00000123 0
T 2
W 4 00000ff0
S 3 ffff
U 2 00001104 00000ff0 00000ff0 0
U 2 01c03104 00000ffe 00000fff 0
U 2 01c05104 00000ffe 00001001 1
U 2 01007104 00000ff8 00000fff 0
U 2 01207104 00000ff9 00001000 1
U 2 01e00c00 000fffff 000fffff 0
U 2 01e02c00 000fffff 00100000 1
T 3
W 6 00000040
U 3 021c0000 00000010 00000010 0
U 3 00804106 00002004 00002007 0
I 8
P 1
K 1 0
W 6 00002000
T 4
R 2
U 4 00200000 00000001 00000001 0
U 4 00400000 00000002 00000002 0
U 4 00600000 00000003 00000003 0
I 4
K 1 1
P 3
R 1
U 4 00800000 00000004 00000004 0
U 4 00a00000 00000005 00000005 0
U 4 00c00000 00000006 00000006 0
U 4 00e00000 00000007 00000007 0

// File: verilog.f
hdl/agu_pkg.sv
hdl/uop_if.sv
hdl/uop_decode.sv
hdl/gpr_file.sv
hdl/seg_file.sv
hdl/rrag.sv
hdl/addr_result.sv
hdl/rrag_top.sv
tests/rrag_sva.sv
tests/rrag_tb.sv
